//--- Makefile
# Verilator build and run of the USB HID decoder testbench

SIM     := verilator
FLAGS   := --binary --timing --assert -j 0
TOP     := usb_hid_decoder_tb
FLIST   := project.f
OBJ_DIR := obj_dir

SRCS    := $(shell cat $(FLIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/usb_hid_decoder_tb.sv
/*
 * USB HID decoder testbench
 * classifies devices, streams boot and gamepad reports, checks each report pulse
 */
`timescale 1ns/1ps
`default_nettype none

module usb_hid_decoder_tb;
    import hid_pkg::*;

    localparam int N_RANDOM   = 6;                       // random frames per device type
    localparam int NUM_FRAMES = 4 + 3 * N_RANDOM + 4 + 1;
    localparam int WATCHDOG   = NUM_FRAMES * 80 + 400;   // cycles

    typedef logic [7:0][7:0] frame_t;  // f[i] is byte i of the frame

    // decoder outputs as the model sees them
    typedef struct packed {
        key_report_t   keys;
        mouse_report_t mouse;
        game_pad_t     game;
    } outs_t;

    typedef struct packed {
        dev_type_e dev;
        outs_t     outs;
    } exp_entry_t;

    logic          usbclk;
    logic          usbrst_n;
    logic          frame_rdy;
    logic          byte_stb;
    byte_t         byte_data;
    logic          save;
    desc_idx_t     save_reg;
    desc_idx_t     save_byte;
    logic          connected;
    dev_type_e     dev_type;
    logic          report;
    key_report_t   keys;
    mouse_report_t mouse;
    game_pad_t     game;

    exp_entry_t exp_q [$];  // one entry per report pulse still due
    outs_t      cur_outs;   // modelled outputs between frames
    dev_type_e  cur_dev;    // type the model believes is attached
    string      test_name;
    frame_t     fb;
    logic [7:0] btn_before; // a b x y sel start shl shr

    usb_hid_decoder #(.REPORT_BYTES(8)) UUT (.*);

    initial begin
        usbclk = 1'b0;
        forever #2 usbclk = ~usbclk;  // 4 ns period
    end

    task automatic stop_with_error(string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
        assert (actual == expected)
        else stop_with_error($sformatf("** Error %s: %s expected %0h, actual %0h",
                                       test_name, what, expected, actual));
    endtask

    // expected outputs after one frame, straight from the report layouts
    function automatic outs_t ref_decode(dev_type_e t, frame_t f, outs_t prev);
        outs_t r;
        logic  rec_ok;
        r      = prev;
        rec_ok = (f[0][1:0] != 2'd2);  // 2 marks a spare adapter record
        case (t)
            dev_keyboard: begin
                r.keys.modifiers = f[0];  // byte 1 reserved
                r.keys.key1      = f[2];
                r.keys.key2      = f[3];
                r.keys.key3      = f[4];
                r.keys.key4      = f[5];
            end
            dev_mouse: begin
                r.mouse.btn = f[0];
                r.mouse.dx  = f[1];
                r.mouse.dy  = f[2];
            end
            dev_gamepad: begin
                if (rec_ok)
                    {r.game.left, r.game.right, r.game.up, r.game.down} = 4'b0000;
                if (f[0] == 8'h00)
                    {r.game.left, r.game.right} = 2'b10;
                else if (f[0] == 8'hff)
                    {r.game.left, r.game.right} = 2'b01;
                if (f[1] == 8'h00)
                    {r.game.up, r.game.down} = 2'b10;
                else if (f[1] == 8'hff)
                    {r.game.up, r.game.down} = 2'b01;
                if (rec_ok) begin
                    if (f[3][7:6] == 2'b00)
                        {r.game.left, r.game.right} = 2'b10;
                    else if (f[3][7:6] == 2'b11)
                        {r.game.left, r.game.right} = 2'b01;
                    if (f[4][7:6] == 2'b00)
                        {r.game.up, r.game.down} = 2'b10;
                    else if (f[4][7:6] == 2'b11)
                        {r.game.up, r.game.down} = 2'b01;
                    {r.game.y, r.game.b, r.game.a, r.game.x} = f[5][7:4];
                    {r.game.start, r.game.sel}               = f[6][5:4];
                    {r.game.shr, r.game.shl}                 = f[6][1:0];
                end
            end
            default: ;  // nothing attached, nothing decoded
        endcase
        return r;
    endfunction

    function automatic frame_t rand_frame();
        frame_t f;
        for (int i = 0; i < 8; i++)
            f[i] = 8'($urandom);
        return f;
    endfunction

    // advance n edges, then 1 ns past the edge
    task automatic step(int n);
        repeat (n) @(posedge usbclk);
        #1;
    endtask

    task automatic send_frame(frame_t f);
        outs_t      nxt;
        exp_entry_t e;
        nxt = ref_decode(cur_dev, f, cur_outs);
        if (cur_dev != dev_none) begin
            e.dev  = cur_dev;
            e.outs = nxt;
            exp_q.push_back(e);
            nxt.mouse.dx = '0;  // report pulse consumes motion
            nxt.mouse.dy = '0;
        end
        cur_outs  = nxt;
        frame_rdy = 1'b1;
        step(2);
        for (int i = 0; i < 8; i++) begin
            byte_data = f[i];
            byte_stb  = 1'b1;  // held two cycles, still one byte
            step(2);
            byte_stb = 1'b0;
            step(2);
        end
        step(2);
        frame_rdy = 1'b0;
        step(8);  // report pulse and motion clear land here
    endtask

    // unplug, replug, send class/subclass/protocol in bytes 0..2, save to regs 4..6
    task automatic classify(byte_t cls, byte_t sub, byte_t proto, dev_type_e exp_dev);
        frame_t f;
        test_name = "classify";
        connected = 1'b0;
        step(4);
        check_value("dev_type after disconnect", 64'(dev_none), 64'(dev_type));
        cur_dev   = dev_none;
        connected = 1'b1;
        step(1);
        f    = rand_frame();
        f[0] = cls;
        f[1] = sub;
        f[2] = proto;
        send_frame(f);  // no device yet, so no pulse
        for (int r = 0; r < 3; r++) begin
            save      = 1'b1;
            save_reg  = desc_idx_t'(4 + r);
            save_byte = desc_idx_t'(r);
            step(1);
            save = 1'b0;
            step(2);
        end
        step(3);
        check_value("dev_type", 64'(exp_dev), 64'(dev_type));
        cur_dev = exp_dev;
    endtask

    // compares outputs at every report pulse
    initial begin
        exp_entry_t e;
        forever begin
            @(negedge usbclk);
            if (report) begin
                assert (exp_q.size() > 0)
                else stop_with_error($sformatf("%s: report pulse with no device attached",
                                               test_name));
                e = exp_q.pop_front();
                check_value("dev_type", 64'(e.dev), 64'(dev_type));
                check_value("keys", 64'(e.outs.keys), 64'(keys));
                check_value("mouse", 64'(e.outs.mouse), 64'(mouse));
                check_value("game", 64'(e.outs.game), 64'(game));
                repeat (2) @(negedge usbclk);
                check_value("motion after report", 64'd0, 64'({mouse.dx, mouse.dy}));
            end
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge usbclk);
        stop_with_error("timeout: test sequence did not finish in time");
    end

    initial begin
        void'($urandom(32'h85a1b3f3));
        usbrst_n  = 1'b0;
        frame_rdy = 1'b0;
        byte_stb  = 1'b0;
        byte_data = '0;
        save      = 1'b0;
        save_reg  = '0;
        save_byte = '0;
        connected = 1'b0;
        cur_outs  = '0;
        cur_dev   = dev_none;
        test_name = "reset";
        repeat (4) @(posedge usbclk);
        #1;
        usbrst_n  = 1'b1;
        connected = 1'b1;
        step(2);

        classify(8'd3, 8'd1, 8'd1, dev_keyboard);
        test_name = "keyboard";
        repeat (N_RANDOM) send_frame(rand_frame());

        classify(8'd3, 8'd1, 8'd2, dev_mouse);
        test_name = "mouse";
        repeat (N_RANDOM) send_frame(rand_frame());

        classify(8'd3, 8'd0, 8'($urandom), dev_gamepad);
        test_name = "gamepad";
        repeat (N_RANDOM) send_frame(rand_frame());

        test_name = "gamepad directed";
        fb = rand_frame();
        {fb[0], fb[1], fb[3], fb[4]} = 32'h00000000;  // left, up
        send_frame(fb);
        fb = rand_frame();
        {fb[0], fb[1], fb[3], fb[4]} = 32'hffffffff;  // right, down
        send_frame(fb);
        fb = rand_frame();
        {fb[0], fb[1], fb[3], fb[4]} = 32'h015aff3f;  // axes in bytes 3/4 only
        send_frame(fb);

        test_name  = "gamepad skip";
        btn_before = cur_outs.game[7:0];
        fb         = rand_frame();
        fb[0]      = 8'h42;  // low bits 2
        fb[1]      = 8'hff;  // still moves down
        send_frame(fb);
        check_value("buttons after skip record", 64'(btn_before), 64'(game[7:0]));

        classify(8'd8, 8'($urandom), 8'($urandom), dev_none);
        test_name = "no device";
        send_frame(rand_frame());

        if (exp_q.size() != 0)
            stop_with_error("missing report pulse at the end of a frame");
        else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- hw/boot_report_decoder.sv
/*
 * Boot report decoder
 * keyboard and mouse fields from boot protocol reports
 */
`timescale 1ns/1ps
`default_nettype none

module boot_report_decoder (
    input  wire logic               usbclk,
    input  wire logic               usbrst_n,
    input  wire hid_pkg::byte_evt_t byte_evt,
    input  wire hid_pkg::dev_type_e dev_type,
    input  wire logic               report,
    output hid_pkg::key_report_t    keys,
    output hid_pkg::mouse_report_t  mouse
);
    import hid_pkg::*;

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            keys  <= '0;
            mouse <= '0;
        end else begin
            // motion is relative, consumed once per report
            if (report) begin
                mouse.dx <= '0;
                mouse.dy <= '0;
            end
            if (byte_evt.valid) begin
                if (dev_type == dev_keyboard) begin
                    case (byte_evt.idx)  // byte 1 reserved
                        4'd0: keys.modifiers <= byte_evt.data;
                        4'd2: keys.key1      <= byte_evt.data;
                        4'd3: keys.key2      <= byte_evt.data;
                        4'd4: keys.key3      <= byte_evt.data;
                        4'd5: keys.key4      <= byte_evt.data;
                        default: ;
                    endcase
                end else if (dev_type == dev_mouse) begin
                    case (byte_evt.idx)
                        4'd0: mouse.btn <= byte_evt.data;
                        4'd1: mouse.dx  <= $signed(byte_evt.data);  // two's complement
                        4'd2: mouse.dy  <= $signed(byte_evt.data);
                        default: ;  // wheel and beyond ignored
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/descriptor_classifier.sv
/*
 * Descriptor classifier
 * holds VID/PID and interface descriptor bytes, and derives the device type
 */
`timescale 1ns/1ps
`default_nettype none

module descriptor_classifier (
    input  wire logic               usbclk,
    input  wire logic               usbrst_n,
    input  wire logic               save,
    input  wire hid_pkg::desc_idx_t save_reg,
    input  wire hid_pkg::byte_t     report_buf_byte,
    input  wire logic               connected,
    output hid_pkg::dev_type_e      dev_type
);
    import hid_pkg::*;

    logic      save_q, save_q2;
    desc_idx_t save_reg_q;   // register of the latest save
    byte_t     save_data_q;  // buffer byte taken with it
    byte_t     desc_regs [7];  // vid_l, vid_h, pid_l, pid_h, class, subclass, protocol
    logic [2:0] con_sr;      // connected history
    logic      save_fall;
    logic      con_fall;
    dev_type_e next_type;

    assign save_fall = save_q2 & ~save_q & (save_reg_q == 4'd6);  // protocol byte just landed
    assign con_fall  = con_sr[2] & ~con_sr[1];

    always_comb begin
        if (desc_regs[4] != HID_CLASS)
            next_type = dev_none;     // not HID at all
        else if (desc_regs[5] != BOOT_SUBCLASS)
            next_type = dev_gamepad;  // generic HID taken as gamepad
        else if (desc_regs[6] == PROTO_KEYBOARD)
            next_type = dev_keyboard;
        else if (desc_regs[6] == PROTO_MOUSE)
            next_type = dev_mouse;
        else
            next_type = dev_none;
    end

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            save_q      <= 1'b0;
            save_q2     <= 1'b0;
            save_reg_q  <= '0;
            save_data_q <= '0;
            con_sr      <= '0;
            dev_type    <= dev_none;
            for (int i = 0; i < 7; i++) begin
                desc_regs[i] <= '0;
            end
        end else begin
            save_q  <= save;
            save_q2 <= save_q;
            con_sr  <= {con_sr[1:0], connected};
            if (save) begin
                save_reg_q  <= save_reg;
                save_data_q <= report_buf_byte;
            end
            if (save_q && save_reg_q < 4'd7)
                desc_regs[save_reg_q[2:0]] <= save_data_q;
            if (con_fall)
                dev_type <= dev_none;  // unplug beats a late classification
            else if (save_fall)
                dev_type <= next_type;
        end
    end

    // only seven descriptor registers exist
    a_save_reg_range: assert property (
        @(posedge usbclk) disable iff (!usbrst_n) save |-> (save_reg < 4'd7)
    );

endmodule

`default_nettype wire

//--- hw/gamepad_decoder.sv
/*
 * Gamepad decoder
 * directions and buttons from generic HID gamepad reports,
 * skipping the spare records of dual controller adapters
 */
`timescale 1ns/1ps
`default_nettype none

module gamepad_decoder (
    input  wire logic               usbclk,
    input  wire logic               usbrst_n,
    input  wire hid_pkg::byte_evt_t byte_evt,
    input  wire hid_pkg::dev_type_e dev_type,
    output hid_pkg::game_pad_t      game
);
    import hid_pkg::*;

    logic  rec_valid;  // current record is not an adapter skip record
    logic  take;
    byte_t d;
    logic  skip_rec;

    assign take     = byte_evt.valid && (dev_type == dev_gamepad);
    assign d        = byte_evt.data;
    assign skip_rec = (d[1:0] == DS2_SKIP_CODE);

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            rec_valid <= 1'b0;
            game      <= '0;
        end else if (take) begin
            case (byte_evt.idx)
                4'd0: begin
                    rec_valid <= !skip_rec;
                    if (!skip_rec) begin
                        // fresh record, directions rebuilt below
                        game.left  <= 1'b0;
                        game.right <= 1'b0;
                        game.up    <= 1'b0;
                        game.down  <= 1'b0;
                    end
                    // some pads put X in byte 0
                    if (d == 8'h00)
                        {game.left, game.right} <= 2'b10;
                    else if (d == 8'hff)
                        {game.left, game.right} <= 2'b01;
                end
                4'd1: begin  // Y axis on those pads
                    if (d == 8'h00)
                        {game.up, game.down} <= 2'b10;
                    else if (d == 8'hff)
                        {game.up, game.down} <= 2'b01;
                end
                4'd3: if (rec_valid) begin  // usual X axis
                    if (d[7:6] == 2'b00)
                        {game.left, game.right} <= 2'b10;
                    else if (d[7:6] == 2'b11)
                        {game.left, game.right} <= 2'b01;
                end
                4'd4: if (rec_valid) begin  // usual Y axis
                    if (d[7:6] == 2'b00)
                        {game.up, game.down} <= 2'b10;
                    else if (d[7:6] == 2'b11)
                        {game.up, game.down} <= 2'b01;
                end
                4'd5: if (rec_valid) begin
                    {game.y, game.b, game.a, game.x} <= d[7:4];
                end
                4'd6: if (rec_valid) begin
                    {game.start, game.sel} <= d[5:4];
                    {game.shr, game.shl}   <= d[1:0];  // shoulders
                end
                default: ;
            endcase
        end
    end

    // opposite directions are exclusive
    a_dirs_one_hot: assert property (
        @(posedge usbclk) disable iff (!usbrst_n)
            !(game.left && game.right) && !(game.up && game.down)
    );

endmodule

`default_nettype wire

//--- hw/hid_pkg.sv
/*
 * HID decoder package
 * byte types, device type encoding and decoded report structs
 */
`default_nettype none

package hid_pkg;

    typedef logic [7:0] byte_t;      // one report or descriptor byte
    typedef logic [3:0] byte_idx_t;  // byte position in a frame, wraps at 16
    typedef logic [3:0] desc_idx_t;  // register or buffer number of a save command

    typedef enum logic [1:0] {
        dev_none     = 2'd0,
        dev_keyboard = 2'd1,
        dev_mouse    = 2'd2,
        dev_gamepad  = 2'd3
    } dev_type_e;

    // one received byte, valid for a single cycle
    typedef struct packed {
        logic      valid;
        byte_idx_t idx;
        byte_t     data;
    } byte_evt_t;

    typedef struct packed {
        byte_t modifiers;
        byte_t key1;
        byte_t key2;
        byte_t key3;
        byte_t key4;
    } key_report_t;

    typedef struct packed {
        byte_t             btn;  // {5'bx, middle, right, left}
        logic signed [7:0] dx;
        logic signed [7:0] dy;
    } mouse_report_t;

    typedef struct packed {
        logic left, right, up, down;
        logic a, b, x, y;
        logic sel, start, shl, shr;
    } game_pad_t;

    localparam byte_t HID_CLASS      = 8'd3;
    localparam byte_t BOOT_SUBCLASS  = 8'd1;
    localparam byte_t PROTO_KEYBOARD = 8'd1;
    localparam byte_t PROTO_MOUSE    = 8'd2;

    localparam logic [1:0] DS2_SKIP_CODE = 2'd2;  // byte 0 low bits of a dual adapter record to skip

endpackage

`default_nettype wire

//--- hw/report_capture.sv
/*
 * Report capture
 * finds byte strobe edges, numbers and buffers frame bytes,
 * pulses report at the end of each frame of a known device
 */
`timescale 1ns/1ps
`default_nettype none

module report_capture #(
    parameter int REPORT_BYTES = 8
) (
    input  wire logic               usbclk,
    input  wire logic               usbrst_n,
    input  wire logic               frame_rdy,
    input  wire logic               byte_stb,
    input  wire hid_pkg::byte_t     byte_data,
    input  wire hid_pkg::desc_idx_t save_byte,
    input  wire hid_pkg::dev_type_e dev_type,
    output hid_pkg::byte_evt_t      byte_evt,
    output hid_pkg::byte_t          report_buf_byte,
    output logic                    report
);
    import hid_pkg::*;

    localparam int IDX_W = (REPORT_BYTES > 1) ? $clog2(REPORT_BYTES) : 1;

    logic      stb_q, stb_q2;  // strobe history for edge find
    logic      rdy_q, rdy_q2;  // frame ready history
    byte_t     data_q;         // data captured alongside stb_q
    byte_idx_t count;          // bytes taken so far in this frame
    byte_t     rpt_buf [REPORT_BYTES];
    logic      stb_rise;
    logic      rdy_fall;

    assign stb_rise = stb_q & ~stb_q2 & rdy_q;  // one byte per strobe, long highs too
    assign rdy_fall = rdy_q2 & ~rdy_q;          // frame over

    // bytes past the buffer read back as zero
    assign report_buf_byte = (save_byte < REPORT_BYTES) ? rpt_buf[IDX_W'(save_byte)] : '0;

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            stb_q    <= 1'b0;
            stb_q2   <= 1'b0;
            rdy_q    <= 1'b0;
            rdy_q2   <= 1'b0;
            data_q   <= '0;
            count    <= '0;
            byte_evt <= '0;
            report   <= 1'b0;
            for (int i = 0; i < REPORT_BYTES; i++) begin
                rpt_buf[i] <= '0;
            end
        end else begin
            stb_q  <= byte_stb;
            stb_q2 <= stb_q;
            rdy_q  <= frame_rdy;
            rdy_q2 <= rdy_q;
            data_q <= byte_data;

            byte_evt.valid <= stb_rise;  // single cycle
            byte_evt.idx   <= count;
            byte_evt.data  <= data_q;

            if (!rdy_q) begin
                count <= '0;  // idle between frames
            end else if (stb_rise) begin
                count <= count + 1'b1;  // wraps at 16
                if (count < REPORT_BYTES)
                    rpt_buf[IDX_W'(count)] <= data_q;
            end

            // no pulse while nothing is attached
            report <= rdy_fall && (dev_type != dev_none);
        end
    end

    // frame end must come well after the last byte of the frame
    a_report_not_with_byte: assert property (
        @(posedge usbclk) disable iff (!usbrst_n) !(report && byte_evt.valid)
    );

endmodule

`default_nettype wire

//--- hw/usb_hid_decoder.sv
/*
 * USB HID report decoder top
 * byte capture, device classification, boot and gamepad decoding
 */
`timescale 1ns/1ps
`default_nettype none

module usb_hid_decoder #(
    parameter int REPORT_BYTES = 8  // report buffer depth
) (
    input  wire logic               usbclk,
    input  wire logic               usbrst_n,
    input  wire logic               frame_rdy,
    input  wire logic               byte_stb,
    input  wire hid_pkg::byte_t     byte_data,
    input  wire logic               save,
    input  wire hid_pkg::desc_idx_t save_reg,
    input  wire hid_pkg::desc_idx_t save_byte,
    input  wire logic               connected,
    output hid_pkg::dev_type_e      dev_type,
    output logic                    report,
    output hid_pkg::key_report_t    keys,
    output hid_pkg::mouse_report_t  mouse,
    output hid_pkg::game_pad_t      game
);
    import hid_pkg::*;

    byte_evt_t byte_evt;         // to both decoders
    byte_t     report_buf_byte;  // buffer read for descriptor saves

    report_capture #(.REPORT_BYTES(REPORT_BYTES)) u_capture (
        .usbclk          (usbclk),
        .usbrst_n        (usbrst_n),
        .frame_rdy       (frame_rdy),
        .byte_stb        (byte_stb),
        .byte_data       (byte_data),
        .save_byte       (save_byte),
        .dev_type        (dev_type),
        .byte_evt        (byte_evt),
        .report_buf_byte (report_buf_byte),
        .report          (report)
    );

    descriptor_classifier u_classifier (
        .usbclk          (usbclk),
        .usbrst_n        (usbrst_n),
        .save            (save),
        .save_reg        (save_reg),
        .report_buf_byte (report_buf_byte),
        .connected       (connected),
        .dev_type        (dev_type)
    );

    boot_report_decoder u_boot (
        .usbclk   (usbclk),
        .usbrst_n (usbrst_n),
        .byte_evt (byte_evt),
        .dev_type (dev_type),
        .report   (report),
        .keys     (keys),
        .mouse    (mouse)
    );

    gamepad_decoder u_gamepad (
        .usbclk   (usbclk),
        .usbrst_n (usbrst_n),
        .byte_evt (byte_evt),
        .dev_type (dev_type),
        .game     (game)
    );

endmodule

`default_nettype wire

//--- project.f
hw/hid_pkg.sv
hw/report_capture.sv
hw/descriptor_classifier.sv
hw/boot_report_decoder.sv
hw/gamepad_decoder.sv
hw/usb_hid_decoder.sv
dv/usb_hid_decoder_tb.sv
